// ==== hdl/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Core word and register file geometry
`define DATA_WIDTH 32
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

// R15 doubles as program counter
`define PC_REG 15
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/corePkg.sv ====
`default_nettype none

package corePkg;

  // Data-processing opcodes keep their instruction encoding
  typedef enum logic [4:0] {
    AluAnd     = 5'd0,
    AluEor     = 5'd1,
    AluSub     = 5'd2,
    AluRsb     = 5'd3,
    AluAdd     = 5'd4,
    AluAdc     = 5'd5,
    AluSbc     = 5'd6,
    AluRsc     = 5'd7,
    AluTst     = 5'd8,
    AluTeq     = 5'd9,
    AluCmp     = 5'd10,
    AluCmn     = 5'd11,
    AluOrr     = 5'd12,
    AluMov     = 5'd13,
    AluBic     = 5'd14,
    AluMvn     = 5'd15,
    AluAddFour = 5'd16
  } aluOpE;

  typedef enum logic [1:0] {
    StFetch,
    StMemRead,
    StDecode,
    StExecute
  } microStateE;

  typedef enum logic [3:0] {
    CondEq, CondNe, CondCs, CondCc, CondMi, CondPl, CondVs, CondVc,
    CondHi, CondLs, CondGe, CondLt, CondGt, CondLe, CondAl
  } condCodeE;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

endpackage

`default_nettype wire

// ==== hdl/microCtrlIf.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

interface microCtrlIf import corePkg::*; ();

  // Microword
  logic aSelPc;
  aluOpE aluOp;
  logic destPc;
  logic rfWrEn;
  logic marEn;
  logic irEn;
  logic flagsEn;

  // Status back to the sequencer
  logic [`DATA_WIDTH-1:0] instr;
  flagsT flags;

  modport sequencer (
    output aSelPc, aluOp, destPc, rfWrEn, marEn, irEn, flagsEn,
    input instr, flags
  );

  modport datapath (
    input aSelPc, aluOp, destPc, rfWrEn, marEn, irEn, flagsEn,
    output instr, flags
  );

endinterface

`default_nettype wire

// ==== hdl/aluUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module aluUnit import corePkg::*; (
  input  wire logic [`DATA_WIDTH-1:0] a,
  input  wire logic [`DATA_WIDTH-1:0] b,
  input  wire aluOpE                  op,
  input  wire flagsT                  inFlags,
  output logic [`DATA_WIDTH-1:0]      result,
  output flagsT                       outFlags
);

  localparam logic [`DATA_WIDTH-1:0] FetchStep = 4;

  logic [`DATA_WIDTH-1:0] addX;
  logic [`DATA_WIDTH-1:0] addY;
  logic                   addCin;
  logic                   arith;
  logic [`DATA_WIDTH:0]   sum;

  // Every arithmetic op maps onto one adder; subtraction adds the inverse
  always_comb
  begin
    addX   = a;
    addY   = b;
    addCin = 1'b0;
    arith  = 1'b1;
    case (op)
      AluSub, AluCmp:
      begin
        addY   = ~b;
        addCin = 1'b1;
      end
      AluRsb:
      begin
        addX   = b;
        addY   = ~a;
        addCin = 1'b1;
      end
      AluAdd, AluCmn: addCin = 1'b0;
      AluAdc: addCin = inFlags.c;
      AluSbc:
      begin
        addY   = ~b;
        addCin = inFlags.c;
      end
      AluRsc:
      begin
        addX   = b;
        addY   = ~a;
        addCin = inFlags.c;
      end
      AluAddFour: addY = FetchStep;
      default: arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, addX} + {1'b0, addY} + {{`DATA_WIDTH{1'b0}}, addCin};

  always_comb
  begin
    case (op)
      AluAnd, AluTst: result = a & b;
      AluEor, AluTeq: result = a ^ b;
      AluOrr: result = a | b;
      AluMov: result = b;
      AluBic: result = a & ~b;
      AluMvn: result = ~b;
      default: result = sum[`DATA_WIDTH-1:0];
    endcase
  end

  always_comb
  begin
    outFlags.n = result[`DATA_WIDTH-1];
    outFlags.z = ~|result;
    // Carry out doubles as NOT borrow thanks to the inverted operand
    outFlags.c = arith ? sum[`DATA_WIDTH] : inFlags.c;
    outFlags.v = arith ? (addX[`DATA_WIDTH-1] == addY[`DATA_WIDTH-1]) &&
                         (sum[`DATA_WIDTH-1] != addX[`DATA_WIDTH-1])
                       : inFlags.v;
  end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module regFile (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  input  wire logic [`REG_ADDR_WIDTH-1:0] rdAddr,
  output logic [`DATA_WIDTH-1:0]          rdData,
  input  wire logic                       wrEn,
  input  wire logic [`REG_ADDR_WIDTH-1:0] wrAddr,
  input  wire logic [`DATA_WIDTH-1:0]     wrData
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
      regs[`PC_REG] <= `RESET_PC;
    end
    else if (wrEn)
      regs[wrAddr] <= wrData;
  end

  // Single combinational read port
  assign rdData = regs[rdAddr];

endmodule

`default_nettype wire

// ==== hdl/dataPath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module dataPath import corePkg::*; (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  microCtrlIf.datapath                    ctrl,
  output logic [`DATA_WIDTH-1:0]          wbAdr,
  input  wire logic [`DATA_WIDTH-1:0]     wbDatI,
  output logic                            retireValid,
  output logic [`REG_ADDR_WIDTH-1:0]      retireReg,
  output logic [`DATA_WIDTH-1:0]          retireData
);

  localparam logic [`REG_ADDR_WIDTH-1:0] PcIdx = `PC_REG;

  logic [`DATA_WIDTH-1:0]     instrQ;
  logic [`DATA_WIDTH-1:0]     marQ;
  flagsT                      flagsQ;

  logic [`REG_ADDR_WIDTH-1:0] rdAddr;
  logic [`REG_ADDR_WIDTH-1:0] wrAddr;
  logic [`DATA_WIDTH-1:0]     rdData;
  logic [`DATA_WIDTH-1:0]     aluResult;
  flagsT                      aluFlags;

  logic [`DATA_WIDTH-1:0]     immExt;
  logic [2*`DATA_WIDTH-1:0]   immRot;
  logic [`DATA_WIDTH-1:0]     immB;

  // Rotate right by twice the rotate field
  assign immExt = {{(`DATA_WIDTH-8){1'b0}}, instrQ[7:0]};
  assign immRot = {immExt, immExt} >> {instrQ[11:8], 1'b0};
  assign immB   = immRot[`DATA_WIDTH-1:0];

  assign rdAddr = ctrl.aSelPc ? PcIdx : instrQ[19:16];
  assign wrAddr = ctrl.destPc ? PcIdx : instrQ[15:12];

  regFile regFileInst (
    .clk    (clk),
    .rstN   (rstN),
    .rdAddr (rdAddr),
    .rdData (rdData),
    .wrEn   (ctrl.rfWrEn),
    .wrAddr (wrAddr),
    .wrData (aluResult)
  );

  aluUnit aluInst (
    .a        (rdData),
    .b        (immB),
    .op       (ctrl.aluOp),
    .inFlags  (flagsQ),
    .result   (aluResult),
    .outFlags (aluFlags)
  );

  always_ff @(posedge clk)
  begin
    if (ctrl.irEn)
      instrQ <= wbDatI;
    if (ctrl.marEn)
      marQ <= rdData;
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      flagsQ <= '0;
    else if (ctrl.flagsEn)
      flagsQ <= aluFlags;
  end

  assign ctrl.instr = instrQ;
  assign ctrl.flags = flagsQ;
  assign wbAdr      = marQ;

  // PC increments are not architectural results
  assign retireValid = ctrl.rfWrEn && !ctrl.destPc;
  assign retireReg   = wrAddr;
  assign retireData  = aluResult;

endmodule

`default_nettype wire

// ==== hdl/microSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module microSequencer import corePkg::*; (
  input  wire logic     clk,
  input  wire logic     rstN,
  microCtrlIf.sequencer ctrl,
  output logic          wbCyc,
  output logic          wbStb,
  input  wire logic     wbAck
);

  microStateE state;
  microStateE stateNext;
  condCodeE   cond;
  flagsT      f;
  logic       condPass;
  logic       writesRd;

  assign cond = condCodeE'(ctrl.instr[31:28]);
  assign f    = ctrl.flags;

  always_comb
  begin
    case (cond)
      CondEq: condPass = f.z;
      CondNe: condPass = !f.z;
      CondCs: condPass = f.c;
      CondCc: condPass = !f.c;
      CondMi: condPass = f.n;
      CondPl: condPass = !f.n;
      CondVs: condPass = f.v;
      CondVc: condPass = !f.v;
      CondHi: condPass = f.c && !f.z;
      CondLs: condPass = !f.c || f.z;
      CondGe: condPass = f.n == f.v;
      CondLt: condPass = f.n != f.v;
      CondGt: condPass = !f.z && (f.n == f.v);
      CondLe: condPass = f.z || (f.n != f.v);
      CondAl: condPass = 1'b1;
      default: condPass = 1'b0;
    endcase
  end

  // TST, TEQ, CMP and CMN share opcode bits 10xx
  assign writesRd = ctrl.instr[24:23] != 2'b10;

  always_comb
  begin
    stateNext = state;
    case (state)
      StFetch: stateNext = StMemRead;
      StMemRead: if (wbAck) stateNext = StDecode;
      StDecode: stateNext = condPass ? StExecute : StFetch;
      StExecute: stateNext = StFetch;
      default: stateNext = StFetch;
    endcase
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      state <= StFetch;
    else
      state <= stateNext;
  end

  // Microword per state
  always_comb
  begin
    ctrl.aSelPc  = 1'b0;
    ctrl.aluOp   = AluAddFour;
    ctrl.destPc  = 1'b0;
    ctrl.rfWrEn  = 1'b0;
    ctrl.marEn   = 1'b0;
    ctrl.irEn    = 1'b0;
    ctrl.flagsEn = 1'b0;
    case (state)
      StFetch:
      begin
        ctrl.aSelPc = 1'b1;
        ctrl.destPc = 1'b1;
        ctrl.rfWrEn = 1'b1;
        ctrl.marEn  = 1'b1;
      end
      StMemRead: ctrl.irEn = wbAck;
      StExecute:
      begin
        ctrl.aluOp   = aluOpE'({1'b0, ctrl.instr[24:21]});
        ctrl.rfWrEn  = writesRd;
        ctrl.flagsEn = ctrl.instr[20];
      end
      default: ;
    endcase
  end

  assign wbCyc = state == StMemRead;
  assign wbStb = state == StMemRead;

  // wbAdr comes from the address register, which only loads on marEn
  reqHeld: assert property (@(posedge clk) disable iff (!rstN)
    (wbStb && !wbAck) |-> !ctrl.marEn ##1 (wbStb && wbCyc && !ctrl.marEn));

  // Slave may only acknowledge an open strobe
  ackInStb: assert property (@(posedge clk) disable iff (!rstN) wbAck |-> wbStb);

endmodule

`default_nettype wire

// ==== hdl/armCore.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module armCore import corePkg::*; (
  input  wire logic                       clk,
  input  wire logic                       rstN,
  output logic                            wbCyc,
  output logic                            wbStb,
  output logic [`DATA_WIDTH-1:0]          wbAdr,
  input  wire logic [`DATA_WIDTH-1:0]     wbDatI,
  input  wire logic                       wbAck,
  output logic                            retireValid,
  output logic [`REG_ADDR_WIDTH-1:0]      retireReg,
  output logic [`DATA_WIDTH-1:0]          retireData,
  output flagsT                           flags
);

  microCtrlIf ctrlBus ();

  microSequencer sequencerInst (
    .clk   (clk),
    .rstN  (rstN),
    .ctrl  (ctrlBus.sequencer),
    .wbCyc (wbCyc),
    .wbStb (wbStb),
    .wbAck (wbAck)
  );

  dataPath dataPathInst (
    .clk         (clk),
    .rstN        (rstN),
    .ctrl        (ctrlBus.datapath),
    .wbAdr       (wbAdr),
    .wbDatI      (wbDatI),
    .retireValid (retireValid),
    .retireReg   (retireReg),
    .retireData  (retireData)
  );

  assign flags = ctrlBus.flags;

endmodule

`default_nettype wire

// ==== tests/armCoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_cfg.svh"

module armCoreTb import corePkg::*; ();

  localparam int InstrCount = 200;
  localparam int WaitLimit = 20;
  localparam int MemWords = 256;

  logic                       clk;
  logic                       rstN;
  logic                       wbCyc;
  logic                       wbStb;
  logic [`DATA_WIDTH-1:0]     wbAdr;
  logic [`DATA_WIDTH-1:0]     wbDatI;
  logic                       wbAck;
  logic                       retireValid;
  logic [`REG_ADDR_WIDTH-1:0] retireReg;
  logic [`DATA_WIDTH-1:0]     retireData;
  flagsT                      flags;

  logic [31:0] progMem [MemWords];
  logic [31:0] modelRegs [16];
  logic        mN;
  logic        mZ;
  logic        mC;
  logic        mV;
  logic        pendValid;
  logic [3:0]  pendReg;
  logic [31:0] pendData;
  logic [31:0] rngState;

  armCore armCore_inst (
    .clk         (clk),
    .rstN        (rstN),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbAdr       (wbAdr),
    .wbDatI      (wbDatI),
    .wbAck       (wbAck),
    .retireValid (retireValid),
    .retireReg   (retireReg),
    .retireData  (retireData),
    .flags       (flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic stepCycle;
    @(posedge clk);
    #2;
  endtask

  task automatic checkIdle;
    assert (!wbCyc)
      else abortRun($sformatf("Error at %0t: wbCyc expected 0, actual %b", $time, wbCyc));
    assert (!wbStb)
      else abortRun($sformatf("Error at %0t: wbStb expected 0, actual %b", $time, wbStb));
    assert (!retireValid)
      else abortRun($sformatf("Error at %0t: retireValid expected 0, actual %b", $time, retireValid));
    assert (flags == 4'b0000)
      else abortRun($sformatf("Error at %0t: flags expected 0000, actual %b", $time, flags));
  endtask

  // ARM condition table on the model flags
  function automatic logic condHolds(input logic [3:0] cc);
    case (cc)
      4'd0: return mZ;
      4'd1: return !mZ;
      4'd2: return mC;
      4'd3: return !mC;
      4'd4: return mN;
      4'd5: return !mN;
      4'd6: return mV;
      4'd7: return !mV;
      4'd8: return mC && !mZ;
      4'd9: return !mC || mZ;
      4'd10: return mN == mV;
      4'd11: return mN != mV;
      4'd12: return !mZ && (mN == mV);
      4'd13: return mZ || (mN != mV);
      default: return 1'b1;
    endcase
  endfunction

  task automatic modelStep(input logic [31:0] ins);
    logic [3:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    logic [32:0] wide;
    logic        cin;
    logic        isSub;
    logic        isArith;
    logic        newC;
    logic        newV;
    int          rot;
    op = ins[24:21];
    a = modelRegs[ins[19:16]];
    rot = 2 * ins[11:8];
    b = {24'b0, ins[7:0]};
    b = (b >> rot) | (b << (32 - rot));
    isArith = (op >= 4'd2 && op <= 4'd7) || op == 4'd10 || op == 4'd11;
    isSub = 1'b0;
    x = a;
    y = b;
    cin = 1'b0;
    case (op)
      4'd2, 4'd10:
      begin
        isSub = 1'b1;
        cin = 1'b1;
      end
      4'd3:
      begin
        isSub = 1'b1;
        x = b;
        y = a;
        cin = 1'b1;
      end
      4'd5: cin = mC;
      4'd6:
      begin
        isSub = 1'b1;
        cin = mC;
      end
      4'd7:
      begin
        isSub = 1'b1;
        x = b;
        y = a;
        cin = mC;
      end
      default: ;
    endcase
    if (isSub)
    begin
      // Carry is NOT borrow
      r = x - y - {31'b0, !cin};
      newC = {1'b0, x} >= ({1'b0, y} + {32'b0, !cin});
      newV = (x[31] != y[31]) && (r[31] != x[31]);
    end
    else if (isArith)
    begin
      wide = {1'b0, x} + {1'b0, y} + {32'b0, cin};
      r = wide[31:0];
      newC = wide[32];
      newV = (x[31] == y[31]) && (r[31] != x[31]);
    end
    else
    begin
      newC = mC;
      newV = mV;
      case (op)
        4'd0, 4'd8: r = a & b;
        4'd1, 4'd9: r = a ^ b;
        4'd12: r = a | b;
        4'd13: r = b;
        4'd14: r = a & ~b;
        default: r = ~b;
      endcase
    end
    if (condHolds(ins[31:28]))
    begin
      if (ins[20])
        {mN, mZ, mC, mV} = {r[31], r == 32'b0, newC, newV};
      // Compare and test ops have no destination
      if (op[3:2] != 2'b10)
      begin
        modelRegs[ins[15:12]] = r;
        pendValid = 1'b1;
        pendReg = ins[15:12];
        pendData = r;
      end
    end
  endtask

  task automatic checkRetire;
    if (retireValid)
    begin
      assert (pendValid) else abortRun("Retire seen for an instruction that writes no register");
      assert (retireReg == pendReg)
        else abortRun($sformatf("Error at %0t: retireReg expected %0d, actual %0d",
                                $time, pendReg, retireReg));
      assert (retireData == pendData)
        else abortRun($sformatf("Error at %0t: retireData expected %h, actual %h",
                                $time, pendData, retireData));
      pendValid = 1'b0;
    end
  endtask

  task automatic waitFetch(input logic [31:0] expAdr);
    int cycles;
    cycles = 0;
    do
    begin
      stepCycle();
      checkRetire();
      cycles++;
      if (cycles > WaitLimit)
        abortRun("Timeout while waiting for the next Wishbone fetch strobe");
    end
    while (!wbStb);
    assert (!pendValid) else abortRun("An expected register write-back never retired");
    assert (wbCyc)
      else abortRun($sformatf("Error at %0t: wbCyc expected 1, actual %b", $time, wbCyc));
    assert (wbAdr == expAdr)
      else abortRun($sformatf("Error at %0t: wbAdr expected %h, actual %h", $time, expAdr, wbAdr));
    assert (flags == {mN, mZ, mC, mV})
      else abortRun($sformatf("Error at %0t: flags expected %b, actual %b",
                              $time, {mN, mZ, mC, mV}, flags));
  endtask

  // Slave answers after 0 to 3 wait cycles
  task automatic serveFetch;
    int          delay;
    logic [31:0] adr;
    adr = wbAdr;
    rngState = xorshift(rngState);
    delay = int'(rngState[1:0]);
    repeat (delay)
    begin
      stepCycle();
      checkRetire();
      assert (wbStb && wbCyc)
        else abortRun("Strobe or cycle dropped before the slave acknowledged");
      assert (wbAdr == adr)
        else abortRun($sformatf("Error at %0t: wbAdr expected %h, actual %h", $time, adr, wbAdr));
    end
    wbAck = 1'b1;
    wbDatI = progMem[adr[9:2]];
    stepCycle();
    wbAck = 1'b0;
    wbDatI = '0;
    modelStep(progMem[adr[9:2]]);
  endtask

  initial
  begin
    logic [31:0] r;
    logic [3:0]  cond;
    rstN = 1'b0;
    wbAck = 1'b0;
    wbDatI = '0;
    rngState = 32'd54536;
    pendValid = 1'b0;
    pendReg = '0;
    pendData = '0;
    {mN, mZ, mC, mV} = 4'b0000;
    for (int i = 0; i < 16; i++)
      modelRegs[i] = '0;
    // Random immediate data-processing program, Rd and Rn kept off R15
    for (int i = 0; i < MemWords; i++)
    begin
      rngState = xorshift(rngState);
      r = rngState;
      cond = (r[26:25] == 2'b00) ? r[31:28] % 4'd15 : 4'd14;
      progMem[i] = {cond, 3'b001, r[3:0], r[4], r[12:9] % 4'd15, r[8:5] % 4'd15,
                    r[16:13], r[24:17]};
    end
    repeat (3)
    begin
      stepCycle();
      checkIdle();
    end
    rstN = 1'b1;
    #1;
    checkIdle();
    for (int i = 0; i < InstrCount; i++)
    begin
      waitFetch(32'(i * 4));
      serveFetch();
    end
    waitFetch(32'(InstrCount * 4));
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/corePkg.sv
hdl/microCtrlIf.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/dataPath.sv
hdl/microSequencer.sv
hdl/armCore.sv
tests/armCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the armCore testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module armCoreTb -o armCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/armCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
